// ==== mam_pkg.sv ====
package mam_pkg;

  //////////////////////////////
  // Debug command opcodes
  //////////////////////////////

  // Single-beat word access from the debug host
  typedef enum logic {
    MAM_OP_READ  = 1'b0,
    MAM_OP_WRITE = 1'b1
  } mam_op_e;

  //////////////////////////////
  // Bus arbiter states
  //////////////////////////////

  // MAM has priority from idle, a locked CPU finishes first
  typedef enum logic [1:0] {
    ARB_IDLE       = 2'd0,
    ARB_ACCESS_MAM = 2'd1,
    ARB_ACCESS_CPU = 2'd2
  } arb_state_e;

endpackage

// ==== mam_cmd_decode.sv ====
`timescale 1ns/1ps

module mam_cmd_decode #(
  parameter int PLEN = 32,
  parameter int XLEN = 32
) (
  input  logic                axi4_in_clk_i,
  input  logic                rst_n_i,

  // Debug command port
  input  logic                cmd_valid_i,
  input  mam_pkg::mam_op_e    cmd_op_i,
  input  logic [PLEN-1:0]     cmd_addr_i,
  input  logic [XLEN-1:0]     cmd_wdata_i,

  // End of the MAM access, from the response capture
  input  logic                req_done_i,

  output logic                busy_o,

  // MAM master request lines
  output logic                mam_hsel_o,
  output logic [PLEN-1:0]     mam_haddr_o,
  output logic [XLEN-1:0]     mam_hwdata_o,
  output logic                mam_hwrite_o,
  output logic                mam_hmastlock_o
);

  import mam_pkg::*;

  logic            busy_q;
  logic [PLEN-1:0] addr_q;
  logic [XLEN-1:0] wdata_q;
  logic            write_q;

  // Command accepted only while no access is pending
  logic            cmd_accept;
  assign cmd_accept = cmd_valid_i && !busy_q;

  // Busy covers the whole locked access
  // Set on an accepted command, cleared after the MAM ready
  always_ff @(posedge axi4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (cmd_accept) begin
      busy_q <= 1'b1;
    end else if (req_done_i) begin
      busy_q <= 1'b0;
    end
  end

  // Request payload, held stable for the whole access
  always_ff @(posedge axi4_in_clk_i) begin
    if (cmd_accept) begin
      addr_q  <= cmd_addr_i;
      wdata_q <= cmd_wdata_i;
      write_q <= (cmd_op_i == MAM_OP_WRITE);
    end
  end

  // Select and lock stay up until the access completes
  assign busy_o          = busy_q;
  assign mam_hsel_o      = busy_q;
  assign mam_hmastlock_o = busy_q;
  assign mam_haddr_o     = addr_q;
  assign mam_hwdata_o    = wdata_q;
  assign mam_hwrite_o    = write_q;

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Host must wait for busy to clear
  a_no_cmd_while_busy : assert property (@(posedge axi4_in_clk_i) disable iff (!rst_n_i)
    cmd_valid_i |-> !busy_o);

  // A done only ends a request that is still held
  a_done_while_locked : assert property (@(posedge axi4_in_clk_i) disable iff (!rst_n_i)
    req_done_i |-> mam_hmastlock_o);

endmodule

// ==== mam_bus_adapter.sv ====
`timescale 1ns/1ps

module mam_bus_adapter #(
  parameter int PLEN      = 32,
  parameter int XLEN      = 32,
  parameter int USE_DEBUG = 1
) (
  input  logic            axi4_in_clk_i,
  input  logic            rst_n_i,

  // CPU master
  input  logic            cpu_hsel_i,
  input  logic [PLEN-1:0] cpu_haddr_i,
  input  logic [XLEN-1:0] cpu_hwdata_i,
  input  logic            cpu_hwrite_i,
  input  logic            cpu_hmastlock_i,
  output logic [XLEN-1:0] cpu_hrdata_o,
  output logic            cpu_hready_o,
  output logic            cpu_hresp_o,

  // MAM master
  input  logic            mam_hsel_i,
  input  logic [PLEN-1:0] mam_haddr_i,
  input  logic [XLEN-1:0] mam_hwdata_i,
  input  logic            mam_hwrite_i,
  input  logic            mam_hmastlock_i,
  output logic [XLEN-1:0] mam_hrdata_o,
  output logic            mam_hready_o,
  output logic            mam_hresp_o,

  // Memory slave
  output logic            mem_hsel_o,
  output logic [PLEN-1:0] mem_haddr_o,
  output logic [XLEN-1:0] mem_hwdata_o,
  output logic            mem_hwrite_o,
  output logic            mem_hmastlock_o,
  input  logic [XLEN-1:0] mem_hrdata_i,
  input  logic            mem_hready_i,
  input  logic            mem_hresp_i
);

  import mam_pkg::*;

  if (USE_DEBUG == 1) begin : g_arb

    arb_state_e arb_state_q;
    arb_state_e arb_state_d;
    logic       grant_cpu;
    logic       grant_mam;
    // Registered bus owner, 0 selects the MAM
    logic       access_cpu_q;

    //////////////////////////////
    // Arbiter FSM
    //////////////////////////////

    always_ff @(posedge axi4_in_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        arb_state_q  <= ARB_IDLE;
        access_cpu_q <= 1'b0;
      end else begin
        arb_state_q <= arb_state_d;
        // Owner follows the state one cycle late
        if (grant_cpu) begin
          access_cpu_q <= 1'b1;
        end else if (grant_mam) begin
          access_cpu_q <= 1'b0;
        end
      end
    end

    always_comb begin
      grant_cpu   = 1'b0;
      grant_mam   = 1'b0;
      arb_state_d = ARB_IDLE;
      case (arb_state_q)
        ARB_IDLE: begin
          // MAM wins a tie
          if (mam_hmastlock_i) begin
            arb_state_d = ARB_ACCESS_MAM;
          end else if (cpu_hmastlock_i) begin
            arb_state_d = ARB_ACCESS_CPU;
          end
        end
        ARB_ACCESS_MAM: begin
          grant_mam = 1'b1;
          if (mam_hmastlock_i) begin
            arb_state_d = ARB_ACCESS_MAM;
          end
        end
        ARB_ACCESS_CPU: begin
          grant_cpu = 1'b1;
          // Locked CPU access runs to completion before the MAM
          if (cpu_hmastlock_i) begin
            arb_state_d = ARB_ACCESS_CPU;
          end else if (mam_hmastlock_i) begin
            arb_state_d = ARB_ACCESS_MAM;
          end
        end
        default: arb_state_d = ARB_IDLE;
      endcase
    end

    //////////////////////////////
    // Request and response muxes
    //////////////////////////////

    // Select reaches memory only when the state agrees with the owner
    // Keeps a late owner switch from sampling the other master
    assign mem_hsel_o      = access_cpu_q ? (cpu_hsel_i & grant_cpu) : (mam_hsel_i & ~grant_cpu);
    assign mem_haddr_o     = access_cpu_q ? cpu_haddr_i : mam_haddr_i;
    assign mem_hwdata_o    = access_cpu_q ? cpu_hwdata_i : mam_hwdata_i;
    assign mem_hwrite_o    = access_cpu_q ? cpu_hwrite_i : mam_hwrite_i;
    assign mem_hmastlock_o = access_cpu_q ? cpu_hmastlock_i : mam_hmastlock_i;

    // Non-owner sees an idle bus and keeps waiting
    assign cpu_hrdata_o = access_cpu_q ? mem_hrdata_i : '0;
    assign cpu_hready_o = access_cpu_q & mem_hready_i;
    assign cpu_hresp_o  = access_cpu_q & mem_hresp_i;
    assign mam_hrdata_o = access_cpu_q ? '0 : mem_hrdata_i;
    assign mam_hready_o = ~access_cpu_q & mem_hready_i;
    assign mam_hresp_o  = ~access_cpu_q & mem_hresp_i;

  end else begin : g_bypass

    // No debug path, CPU owns the memory
    assign mem_hsel_o      = cpu_hsel_i;
    assign mem_haddr_o     = cpu_haddr_i;
    assign mem_hwdata_o    = cpu_hwdata_i;
    assign mem_hwrite_o    = cpu_hwrite_i;
    assign mem_hmastlock_o = cpu_hmastlock_i;
    assign cpu_hrdata_o    = mem_hrdata_i;
    assign cpu_hready_o    = mem_hready_i;
    assign cpu_hresp_o     = mem_hresp_i;
    assign mam_hrdata_o    = '0;
    assign mam_hready_o    = 1'b0;
    assign mam_hresp_o     = 1'b0;

  end

  // Each response goes back to a master that still holds its lock
  a_ready_locked_master : assert property (@(posedge axi4_in_clk_i) disable iff (!rst_n_i)
    mem_hready_i |-> (cpu_hready_o && cpu_hmastlock_i) || (mam_hready_o && mam_hmastlock_i));

endmodule

// ==== mam_word_mem.sv ====
`timescale 1ns/1ps

module mam_word_mem #(
  parameter int PLEN      = 32,
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 64
) (
  input  logic            axi4_in_clk_i,
  input  logic            rst_n_i,
  input  logic            mem_hsel_i,
  input  logic [PLEN-1:0] mem_haddr_i,
  input  logic [XLEN-1:0] mem_hwdata_i,
  input  logic            mem_hwrite_i,
  output logic [XLEN-1:0] mem_hrdata_o,
  output logic            mem_hready_o,
  output logic            mem_hresp_o
);

  // Byte offset inside a word, then word index
  localparam int BYTE_AW = $clog2(XLEN / 8);
  localparam int WORD_AW = PLEN - BYTE_AW;
  localparam int IDX_W   = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam logic [PLEN-1:0] BYTE_MASK = PLEN'((1 << BYTE_AW) - 1);

  logic [XLEN-1:0]    mem_q [MEM_WORDS];
  logic [WORD_AW-1:0] word_addr;
  logic [IDX_W-1:0]   word_idx;
  logic               addr_err;
  logic               sample;

  assign word_addr = mem_haddr_i[PLEN-1:BYTE_AW];
  assign word_idx  = word_addr[IDX_W-1:0];

  // Out of range or not word aligned
  assign addr_err = (word_addr >= WORD_AW'(MEM_WORDS)) || ((mem_haddr_i & BYTE_MASK) != '0);

  // New request only when no response is on the bus
  assign sample = mem_hsel_i && !mem_hready_o;

  //////////////////////////////
  // Storage and response
  //////////////////////////////

  always_ff @(posedge axi4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mem_hready_o <= 1'b0;
      mem_hresp_o  <= 1'b0;
      mem_hrdata_o <= '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      // Ready is a single-cycle pulse
      mem_hready_o <= sample;
      if (sample) begin
        mem_hresp_o  <= addr_err;
        mem_hrdata_o <= (addr_err || mem_hwrite_i) ? '0 : mem_q[word_idx];
        // Failed write leaves the array alone
        if (mem_hwrite_i && !addr_err) begin
          mem_q[word_idx] <= mem_hwdata_i;
        end
      end
    end
  end

endmodule

// ==== mam_result.sv ====
`timescale 1ns/1ps

module mam_result #(
  parameter int XLEN = 32
) (
  input  logic            axi4_in_clk_i,
  input  logic            rst_n_i,

  // MAM response lines from the adapter
  input  logic            mam_hready_i,
  input  logic [XLEN-1:0] mam_hrdata_i,
  input  logic            mam_hresp_i,
  input  logic            mam_hwrite_i,

  // Ends the held request in the decoder
  output logic            req_done_o,

  // Response to the debug host
  output logic            rsp_valid_o,
  output logic [XLEN-1:0] rsp_rdata_o,
  output logic            rsp_err_o,
  output logic [15:0]     err_count_o
);

  logic [15:0] err_count_q;

  // Only consumer of the MAM ready
  assign req_done_o = mam_hready_i;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge axi4_in_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      err_count_q <= '0;
    end else begin
      rsp_valid_o <= mam_hready_i;
      // Saturating count of failed MAM accesses
      if (mam_hready_i && mam_hresp_i && (err_count_q != 16'hffff)) begin
        err_count_q <= err_count_q + 16'd1;
      end
    end
  end

  // Response payload, writes report zero data
  always_ff @(posedge axi4_in_clk_i) begin
    if (mam_hready_i) begin
      rsp_err_o   <= mam_hresp_i;
      rsp_rdata_o <= mam_hwrite_i ? '0 : mam_hrdata_i;
    end
  end

  assign err_count_o = err_count_q;

endmodule

// ==== mam_dbg_top.sv ====
`timescale 1ns/1ps

module mam_dbg_top #(
  parameter int PLEN      = 32,
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 64,
  parameter int USE_DEBUG = 1
) (
  input  logic             axi4_in_clk_i,
  input  logic             rst_n_i,

  // Debug command and response
  input  logic             cmd_valid_i,
  input  mam_pkg::mam_op_e cmd_op_i,
  input  logic [PLEN-1:0]  cmd_addr_i,
  input  logic [XLEN-1:0]  cmd_wdata_i,
  output logic             busy_o,
  output logic             rsp_valid_o,
  output logic [XLEN-1:0]  rsp_rdata_o,
  output logic             rsp_err_o,
  output logic [15:0]      err_count_o,

  // CPU bus port
  input  logic             cpu_hsel_i,
  input  logic [PLEN-1:0]  cpu_haddr_i,
  input  logic [XLEN-1:0]  cpu_hwdata_i,
  input  logic             cpu_hwrite_i,
  input  logic             cpu_hmastlock_i,
  output logic [XLEN-1:0]  cpu_hrdata_o,
  output logic             cpu_hready_o,
  output logic             cpu_hresp_o
);

  // MAM bus
  logic            mam_hsel;
  logic [PLEN-1:0] mam_haddr;
  logic [XLEN-1:0] mam_hwdata;
  logic            mam_hwrite;
  logic            mam_hmastlock;
  logic [XLEN-1:0] mam_hrdata;
  logic            mam_hready;
  logic            mam_hresp;
  logic            req_done;

  // Memory bus
  logic            mem_hsel;
  logic [PLEN-1:0] mem_haddr;
  logic [XLEN-1:0] mem_hwdata;
  logic            mem_hwrite;
  logic [XLEN-1:0] mem_hrdata;
  logic            mem_hready;
  logic            mem_hresp;

  //////////////////////////////
  // Decode
  //////////////////////////////

  mam_cmd_decode #(
    .PLEN(PLEN),
    .XLEN(XLEN)
  ) i_decode (
    .axi4_in_clk_i  (axi4_in_clk_i),
    .rst_n_i        (rst_n_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_wdata_i    (cmd_wdata_i),
    .req_done_i     (req_done),
    .busy_o         (busy_o),
    .mam_hsel_o     (mam_hsel),
    .mam_haddr_o    (mam_haddr),
    .mam_hwdata_o   (mam_hwdata),
    .mam_hwrite_o   (mam_hwrite),
    .mam_hmastlock_o(mam_hmastlock)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  mam_bus_adapter #(
    .PLEN     (PLEN),
    .XLEN     (XLEN),
    .USE_DEBUG(USE_DEBUG)
  ) i_adapter (
    .axi4_in_clk_i  (axi4_in_clk_i),
    .rst_n_i        (rst_n_i),
    .cpu_hsel_i     (cpu_hsel_i),
    .cpu_haddr_i    (cpu_haddr_i),
    .cpu_hwdata_i   (cpu_hwdata_i),
    .cpu_hwrite_i   (cpu_hwrite_i),
    .cpu_hmastlock_i(cpu_hmastlock_i),
    .cpu_hrdata_o   (cpu_hrdata_o),
    .cpu_hready_o   (cpu_hready_o),
    .cpu_hresp_o    (cpu_hresp_o),
    .mam_hsel_i     (mam_hsel),
    .mam_haddr_i    (mam_haddr),
    .mam_hwdata_i   (mam_hwdata),
    .mam_hwrite_i   (mam_hwrite),
    .mam_hmastlock_i(mam_hmastlock),
    .mam_hrdata_o   (mam_hrdata),
    .mam_hready_o   (mam_hready),
    .mam_hresp_o    (mam_hresp),
    .mem_hsel_o     (mem_hsel),
    .mem_haddr_o    (mem_haddr),
    .mem_hwdata_o   (mem_hwdata),
    .mem_hwrite_o   (mem_hwrite),
    // Memory slave has no lock input
    .mem_hmastlock_o(),
    .mem_hrdata_i   (mem_hrdata),
    .mem_hready_i   (mem_hready),
    .mem_hresp_i    (mem_hresp)
  );

  mam_word_mem #(
    .PLEN     (PLEN),
    .XLEN     (XLEN),
    .MEM_WORDS(MEM_WORDS)
  ) i_mem (
    .axi4_in_clk_i(axi4_in_clk_i),
    .rst_n_i      (rst_n_i),
    .mem_hsel_i   (mem_hsel),
    .mem_haddr_i  (mem_haddr),
    .mem_hwdata_i (mem_hwdata),
    .mem_hwrite_i (mem_hwrite),
    .mem_hrdata_o (mem_hrdata),
    .mem_hready_o (mem_hready),
    .mem_hresp_o  (mem_hresp)
  );

  //////////////////////////////
  // Result
  //////////////////////////////

  mam_result #(
    .XLEN(XLEN)
  ) i_result (
    .axi4_in_clk_i(axi4_in_clk_i),
    .rst_n_i      (rst_n_i),
    .mam_hready_i (mam_hready),
    .mam_hrdata_i (mam_hrdata),
    .mam_hresp_i  (mam_hresp),
    .mam_hwrite_i (mam_hwrite),
    .req_done_o   (req_done),
    .rsp_valid_o  (rsp_valid_o),
    .rsp_rdata_o  (rsp_rdata_o),
    .rsp_err_o    (rsp_err_o),
    .err_count_o  (err_count_o)
  );

endmodule

// ==== tb_mam_dbg_pkg.sv ====
package tb_mam_dbg_pkg;

  import mam_pkg::*;

  // DUT geometry as built by the testbench
  localparam int TB_PLEN      = 32;
  localparam int TB_XLEN      = 32;
  localparam int TB_MEM_WORDS = 64;
  localparam int TB_BYTE_AW   = $clog2(TB_XLEN / 8);

  // Random part of the table
  localparam logic [31:0] RAND_SEED    = 32'h9247b170;
  localparam int          RAND_ENTRIES = 40;

  typedef enum logic {
    MASTER_CPU = 1'b0,
    MASTER_MAM = 1'b1
  } master_e;

  // One table row, request plus expected response
  typedef struct packed {
    master_e            master;
    mam_op_e            op;
    logic [TB_PLEN-1:0] addr;
    logic [TB_XLEN-1:0] wdata;
    logic [TB_XLEN-1:0] exp_rdata;
    logic               exp_err;
  } stim_t;

  //////////////////////////////
  // Reference memory model
  //////////////////////////////

  logic [TB_XLEN-1:0] ref_mem [TB_MEM_WORDS];

  // 32-bit xorshift, shifts 13, 17, 5
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Memory comes out of reset all zero
  function automatic void clear_ref_mem();
    foreach (ref_mem[i]) begin
      ref_mem[i] = '0;
    end
  endfunction

  // Applies one access in program order and returns the row with its expected response
  // Word past the end or nonzero offset bits give an error, zero data and no update
  function automatic stim_t ref_access(input master_e master, input mam_op_e op,
                                       input logic [TB_PLEN-1:0] addr,
                                       input logic [TB_XLEN-1:0] wdata);
    stim_t              row;
    logic [TB_PLEN-1:0] word;
    row.master    = master;
    row.op        = op;
    row.addr      = addr;
    row.wdata     = wdata;
    word          = addr >> TB_BYTE_AW;
    row.exp_err   = (word >= TB_MEM_WORDS) || (addr[TB_BYTE_AW-1:0] != '0);
    // Writes answer with zero data
    row.exp_rdata = '0;
    if (!row.exp_err) begin
      if (op == MAM_OP_WRITE) begin
        ref_mem[int'(word)] = wdata;
      end else begin
        row.exp_rdata = ref_mem[int'(word)];
      end
    end
    return row;
  endfunction

endpackage

// ==== tb_mam_dbg.sv ====
`timescale 1ns/1ps

module tb_mam_dbg;

  import mam_pkg::*;
  import tb_mam_dbg_pkg::*;

  localparam int PLEN      = TB_PLEN;
  localparam int XLEN      = TB_XLEN;
  localparam int MEM_WORDS = TB_MEM_WORDS;

  logic            clk;
  logic            rst_n;
  logic            cmd_valid;
  mam_op_e         cmd_op;
  logic [PLEN-1:0] cmd_addr;
  logic [XLEN-1:0] cmd_wdata;
  logic            busy;
  logic            rsp_valid;
  logic [XLEN-1:0] rsp_rdata;
  logic            rsp_err;
  logic [15:0]     err_count;
  logic            cpu_hsel;
  logic [PLEN-1:0] cpu_haddr;
  logic [XLEN-1:0] cpu_hwdata;
  logic            cpu_hwrite;
  logic            cpu_hmastlock;
  logic [XLEN-1:0] cpu_hrdata;
  logic            cpu_hready;
  logic            cpu_hresp;

  stim_t           tbl [$];
  int              cycle_cnt = 0;
  int              timeout_cycles = 0;
  int              mam_done_cyc;
  int              cpu_done_cyc;
  logic [XLEN-1:0] cpu_rdata_cap;
  logic            cpu_resp_cap;
  logic [15:0]     exp_errs;
  stim_t           c_mam;
  stim_t           c_cpu;
  arb_state_e      arb_state;

  // Arbiter state, only for error lines
  assign arb_state = i_dut.i_adapter.g_arb.arb_state_q;

  mam_dbg_top #(
    .PLEN     (PLEN),
    .XLEN     (XLEN),
    .MEM_WORDS(MEM_WORDS),
    .USE_DEBUG(1)
  ) i_dut (
    .axi4_in_clk_i  (clk),
    .rst_n_i        (rst_n),
    .cmd_valid_i    (cmd_valid),
    .cmd_op_i       (cmd_op),
    .cmd_addr_i     (cmd_addr),
    .cmd_wdata_i    (cmd_wdata),
    .busy_o         (busy),
    .rsp_valid_o    (rsp_valid),
    .rsp_rdata_o    (rsp_rdata),
    .rsp_err_o      (rsp_err),
    .err_count_o    (err_count),
    .cpu_hsel_i     (cpu_hsel),
    .cpu_haddr_i    (cpu_haddr),
    .cpu_hwdata_i   (cpu_hwdata),
    .cpu_hwrite_i   (cpu_hwrite),
    .cpu_hmastlock_i(cpu_hmastlock),
    .cpu_hrdata_o   (cpu_hrdata),
    .cpu_hready_o   (cpu_hready),
    .cpu_hresp_o    (cpu_hresp)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit scales with the table
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
      abort_run($sformatf("Timeout: the DUT gave no response within %0d cycles", cycle_cnt));
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  //////////////////////////////
  // Bus drivers
  //////////////////////////////

  // One-cycle command pulse, returns on the response pulse
  task automatic mam_access(input mam_op_e op, input logic [PLEN-1:0] addr,
                            input logic [XLEN-1:0] wdata);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd_op    <= op;
    cmd_addr  <= addr;
    cmd_wdata <= wdata;
    @(posedge clk);
    cmd_valid <= 1'b0;
    @(negedge clk);
    while (!rsp_valid) @(negedge clk);
    mam_done_cyc = cycle_cnt;
  endtask

  // Locked CPU access, held until ready, lock dropped after it
  task automatic cpu_access(input mam_op_e op, input logic [PLEN-1:0] addr,
                            input logic [XLEN-1:0] wdata);
    @(posedge clk);
    cpu_hsel      <= 1'b1;
    cpu_hmastlock <= 1'b1;
    cpu_haddr     <= addr;
    cpu_hwdata    <= wdata;
    cpu_hwrite    <= (op == MAM_OP_WRITE);
    @(negedge clk);
    while (!cpu_hready) @(negedge clk);
    cpu_rdata_cap = cpu_hrdata;
    cpu_resp_cap  = cpu_hresp;
    cpu_done_cyc  = cycle_cnt;
    @(posedge clk);
    cpu_hsel      <= 1'b0;
    cpu_hmastlock <= 1'b0;
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_mam_rsp(input logic [XLEN-1:0] exp_rdata, input logic exp_err,
                               input string what);
    if (rsp_rdata !== exp_rdata || rsp_err !== exp_err) begin
      abort_run($sformatf("FAILED @ %0t: %s MAM rdata %h err %b, expected %h err %b (%s)",
                          $time, what, rsp_rdata, rsp_err, exp_rdata, exp_err, arb_state.name()));
    end
  endtask

  task automatic check_cpu_rsp(input logic [XLEN-1:0] exp_rdata, input logic exp_err,
                               input string what);
    if (cpu_rdata_cap !== exp_rdata || cpu_resp_cap !== exp_err) begin
      abort_run($sformatf("FAILED @ %0t: %s CPU rdata %h resp %b, expected %h resp %b (%s)",
                          $time, what, cpu_rdata_cap, cpu_resp_cap, exp_rdata, exp_err,
                          arb_state.name()));
    end
  endtask

  task automatic check_count(input logic [15:0] exp_count, input string what);
    if (err_count !== exp_count) begin
      abort_run($sformatf("FAILED @ %0t: %s error count %0d, expected %0d",
                          $time, what, err_count, exp_count));
    end
  endtask

  task automatic check_low(input logic level, input string what);
    if (level !== 1'b0) begin
      abort_run($sformatf("FAILED @ %0t: %s is %b, expected 0", $time, what, level));
    end
  endtask

  //////////////////////////////
  // Stimulus table
  //////////////////////////////

  function automatic void add_entry(input master_e master, input mam_op_e op,
                                    input logic [PLEN-1:0] addr, input logic [XLEN-1:0] wdata);
    tbl.push_back(ref_access(master, op, addr, wdata));
  endfunction

  function automatic void build_table();
    logic [31:0]     rnd;
    logic [31:0]     ctl;
    logic [PLEN-1:0] addr;
    clear_ref_mem();
    // MAM writes then reads, 0x20 never written
    add_entry(MASTER_MAM, MAM_OP_WRITE, 32'h0000_0000, 32'h1234_5678);
    add_entry(MASTER_MAM, MAM_OP_WRITE, 32'h0000_0004, 32'hdead_beef);
    add_entry(MASTER_MAM, MAM_OP_WRITE, 32'h0000_00fc, 32'ha5a5_0f0f);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_0000, '0);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_0004, '0);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_00fc, '0);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_0020, '0);
    // CPU path, data shared both ways
    add_entry(MASTER_CPU, MAM_OP_WRITE, 32'h0000_0040, 32'h0bad_f00d);
    add_entry(MASTER_CPU, MAM_OP_READ,  32'h0000_0040, '0);
    add_entry(MASTER_CPU, MAM_OP_READ,  32'h0000_0004, '0);
    add_entry(MASTER_CPU, MAM_OP_WRITE, 32'h0000_0080, 32'h7777_1111);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_0080, '0);
    // Range and alignment errors, then proof that nothing changed
    add_entry(MASTER_MAM, MAM_OP_WRITE, 32'h0000_0100, 32'hcafe_f00d);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_0102, '0);
    add_entry(MASTER_MAM, MAM_OP_WRITE, 32'h0000_0001, 32'hffff_ffff);
    add_entry(MASTER_MAM, MAM_OP_READ,  32'h0000_0000, '0);
    add_entry(MASTER_CPU, MAM_OP_WRITE, 32'h0000_0042, 32'hffff_ffff);
    add_entry(MASTER_CPU, MAM_OP_READ,  32'h0003_ff00, '0);
    add_entry(MASTER_CPU, MAM_OP_READ,  32'h0000_0040, '0);
    // Random mix over the low 16 words, with some bad addresses
    rnd = RAND_SEED;
    repeat (RAND_ENTRIES) begin
      rnd = xorshift32(rnd);
      ctl = rnd;
      rnd = xorshift32(rnd);
      case (ctl[14:12])
        3'd0:    addr = 32'h0000_0100 + {26'd0, ctl[7:4], 2'b00};
        3'd1:    addr = {26'd0, ctl[7:4], 2'b10};
        default: addr = {26'd0, ctl[7:4], 2'b00};
      endcase
      add_entry(ctl[0] ? MASTER_MAM : MASTER_CPU, ctl[1] ? MAM_OP_WRITE : MAM_OP_READ,
                addr, rnd);
    end
    // Ends on a CPU access so the CPU owns the bus when the contention starts
    add_entry(MASTER_CPU, MAM_OP_READ, 32'h0000_0000, '0);
  endfunction

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd_op        = MAM_OP_READ;
    cmd_addr      = '0;
    cmd_wdata     = '0;
    cpu_hsel      = 1'b0;
    cpu_haddr     = '0;
    cpu_hwdata    = '0;
    cpu_hwrite    = 1'b0;
    cpu_hmastlock = 1'b0;
    exp_errs      = '0;
    build_table();
    // Table plus five accesses after it, 40 cycles each, plus reset
    timeout_cycles = (tbl.size() + 5) * 40 + 16;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_low(busy, "busy after reset");
    check_low(rsp_valid, "rsp_valid after reset");
    check_low(cpu_hready, "cpu_hready after reset");
    check_count(16'd0, "after reset");

    foreach (tbl[i]) begin
      if (tbl[i].master == MASTER_MAM) begin
        mam_access(tbl[i].op, tbl[i].addr, tbl[i].wdata);
        check_mam_rsp(tbl[i].exp_rdata, tbl[i].exp_err, $sformatf("entry %0d", i));
        // Only MAM errors are counted
        if (tbl[i].exp_err) begin
          exp_errs = exp_errs + 16'd1;
        end
      end else begin
        cpu_access(tbl[i].op, tbl[i].addr, tbl[i].wdata);
        check_cpu_rsp(tbl[i].exp_rdata, tbl[i].exp_err, $sformatf("entry %0d", i));
      end
      check_count(exp_errs, $sformatf("entry %0d", i));
    end

    // Both locks reach the arbiter on the same edge, MAM wins from idle
    repeat (2) @(posedge clk);
    c_mam = ref_access(MASTER_MAM, MAM_OP_WRITE, 32'h0000_0030, 32'h5a5a_c3c3);
    c_cpu = ref_access(MASTER_CPU, MAM_OP_READ, 32'h0000_0030, '0);
    fork
      mam_access(c_mam.op, c_mam.addr, c_mam.wdata);
      begin
        @(posedge clk);
        cpu_access(c_cpu.op, c_cpu.addr, c_cpu.wdata);
      end
    join
    check_mam_rsp(c_mam.exp_rdata, c_mam.exp_err, "contention from idle");
    check_cpu_rsp(c_cpu.exp_rdata, c_cpu.exp_err, "contention from idle");
    if (mam_done_cyc >= cpu_done_cyc) begin
      abort_run("Contention from idle: the CPU access ended before the MAM response");
    end

    // MAM access hands the bus owner back to the MAM
    repeat (2) @(posedge clk);
    c_mam = ref_access(MASTER_MAM, MAM_OP_READ, 32'h0000_0030, '0);
    mam_access(c_mam.op, c_mam.addr, c_mam.wdata);
    check_mam_rsp(c_mam.exp_rdata, c_mam.exp_err, "owner back to MAM");

    // CPU granted first, MAM lock rises a cycle later and waits for the CPU lock to drop
    repeat (2) @(posedge clk);
    c_cpu = ref_access(MASTER_CPU, MAM_OP_WRITE, 32'h0000_0034, 32'h0f1e_2d3c);
    c_mam = ref_access(MASTER_MAM, MAM_OP_READ, 32'h0000_0034, '0);
    fork
      cpu_access(c_cpu.op, c_cpu.addr, c_cpu.wdata);
      mam_access(c_mam.op, c_mam.addr, c_mam.wdata);
    join
    check_cpu_rsp(c_cpu.exp_rdata, c_cpu.exp_err, "locked CPU first");
    check_mam_rsp(c_mam.exp_rdata, c_mam.exp_err, "locked CPU first");
    if (cpu_done_cyc >= mam_done_cyc) begin
      abort_run("Locked CPU access: the MAM response came before the CPU finished");
    end
    check_count(exp_errs, "after contention");

    repeat (2) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== all.f ====
mam_pkg.sv
mam_cmd_decode.sv
mam_bus_adapter.sv
mam_word_mem.sv
mam_result.sv
mam_dbg_top.sv
tb_mam_dbg_pkg.sv
tb_mam_dbg.sv

// ==== Makefile ====
# Verilator build and run for the debug memory-access subsystem

VERILATOR ?= verilator
TOP       ?= tb_mam_dbg
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= PASS: all tests

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
